/* hdl/api_regs.sv */
//----------------------------------------
// Read-only register block
// Read MSB first, the LSB is latched then
// Unknown addresses read as zero
//----------------------------------------

`timescale 1ns/10ps

`include "nts_defines.svh"

module api_regs (
  input  logic                           i_clk,
  input  logic                           i_areset,
  input  logic                           i_api_cs,
  input  logic [`NTS_API_ADDR_BITS-1:0]  i_api_address,
  input  nts_pkg::count_t                i_frames,
  input  nts_pkg::count_t                i_good,
  input  nts_pkg::count_t                i_bad,
  input  nts_pkg::count_t                i_dispatched,
  input  nts_pkg::count_t                i_bytes_rx,
  input  nts_pkg::buf_state_e            i_buf_state [2],
  output nts_pkg::reg_t                  o_api_read_data
);

  localparam logic [63:0] CORE_NAME    = `NTS_CORE_NAME;
  localparam logic [31:0] CORE_VERSION = `NTS_CORE_VERSION;

  nts_pkg::count_t cnt [5];   // Bytes, frames, good, bad, dispatched
  nts_pkg::reg_t   snap [5];  // Low words, same order
  logic [4:0]      snap_we;

  assign cnt[0] = i_bytes_rx;
  assign cnt[1] = i_frames;
  assign cnt[2] = i_good;
  assign cnt[3] = i_bad;
  assign cnt[4] = i_dispatched;

  //----------------------------------------
  // Read decode
  //----------------------------------------

  always_comb
  begin
    o_api_read_data = '0;
    snap_we         = '0;
    if (i_api_cs)
    begin
      case (nts_pkg::api_addr_e'(i_api_address))
        nts_pkg::REG_NAME0:   o_api_read_data = CORE_NAME[63:32];
        nts_pkg::REG_NAME1:   o_api_read_data = CORE_NAME[31:0];
        nts_pkg::REG_VERSION: o_api_read_data = CORE_VERSION;
        nts_pkg::REG_STATUS:
        begin
          o_api_read_data[0] = (i_buf_state[0] == nts_pkg::BUF_EMPTY);
          o_api_read_data[1] = (i_buf_state[1] == nts_pkg::BUF_EMPTY);
          o_api_read_data[2] = (i_buf_state[0] == nts_pkg::BUF_READY) ||
                               (i_buf_state[1] == nts_pkg::BUF_READY);
        end
        nts_pkg::REG_BYTES_MSB:
        begin
          o_api_read_data = cnt[0][63:32];
          snap_we[0]      = 1'b1;
        end
        nts_pkg::REG_BYTES_LSB:  o_api_read_data = snap[0];
        nts_pkg::REG_FRAMES_MSB:
        begin
          o_api_read_data = cnt[1][63:32];
          snap_we[1]      = 1'b1;
        end
        nts_pkg::REG_FRAMES_LSB: o_api_read_data = snap[1];
        nts_pkg::REG_GOOD_MSB:
        begin
          o_api_read_data = cnt[2][63:32];
          snap_we[2]      = 1'b1;
        end
        nts_pkg::REG_GOOD_LSB:   o_api_read_data = snap[2];
        nts_pkg::REG_BAD_MSB:
        begin
          o_api_read_data = cnt[3][63:32];
          snap_we[3]      = 1'b1;
        end
        nts_pkg::REG_BAD_LSB:    o_api_read_data = snap[3];
        nts_pkg::REG_DISP_MSB:
        begin
          o_api_read_data = cnt[4][63:32];
          snap_we[4]      = 1'b1;
        end
        nts_pkg::REG_DISP_LSB:   o_api_read_data = snap[4];
        default: ;
      endcase
    end
  end

  // Low word held from the MSB read
  always_ff @(posedge i_clk or posedge i_areset)
  begin
    if (i_areset)
    begin
      for (int i = 0; i < 5; i++)
        snap[i] <= '0;
    end
    else
    begin
      for (int i = 0; i < 5; i++)
        if (snap_we[i])
          snap[i] <= cnt[i][31:0];
    end
  end

endmodule

/* hdl/frame_buffer.sv */
//----------------------------------------
// Ping-pong frame buffers
// One buffer captures while the other reads
// No back-pressure on the read stream
// A bad strobe only aborts a filling buffer
//----------------------------------------

`timescale 1ns/10ps

`include "nts_defines.svh"

module frame_buffer (
  input  logic                i_clk,
  input  logic                i_areset,
  input  nts_pkg::word_t      i_word,
  input  logic                i_word_valid,
  input  logic                i_sof,
  input  nts_pkg::dv_t        i_rx_data_valid,
  input  logic                i_rx_good_frame,
  input  logic                i_rx_bad_frame,
  input  logic                i_fifo_rd_start,
  input  logic                i_packet_discard,
  output logic                o_packet_available,
  output nts_pkg::buf_addr_t  o_dispatch_counter,
  output nts_pkg::dv_t        o_dispatch_data_valid,
  output logic                o_fifo_empty,
  output logic                o_fifo_rd_valid,
  output nts_pkg::word_t      o_fifo_rd_data,
  output logic                o_dispatch_started,
  output nts_pkg::buf_state_e o_buf_state [2]
);

  localparam int DEPTH = 1 << `NTS_ADDR_WIDTH;

  logic                cur;            // Buffer taking MAC data
  logic                rd_sel;         // Buffer being read out
  nts_pkg::buf_state_e state [2];
  nts_pkg::buf_addr_t  counter [2];    // Index of last stored word
  nts_pkg::dv_t        data_valid [2]; // Mask of last stored word
  nts_pkg::word_t      mem [2][DEPTH];

  logic                wr_en;
  nts_pkg::buf_addr_t  wr_addr;
  nts_pkg::buf_addr_t  r_addr;
  nts_pkg::word_t      rd_word;
  logic                rd_issue;       // rd_word holds a frame word
  logic                fifo_empty;
  logic                fifo_rd_valid;

  assign rd_sel = ~cur;

  // Write in the same cycle as the valid word
  always_comb
  begin
    wr_en   = 1'b0;
    wr_addr = counter[cur];
    if (i_word_valid && !i_rx_bad_frame)
    begin
      if (state[cur] == nts_pkg::BUF_EMPTY)
      begin
        wr_en   = 1'b1;
        wr_addr = '0;
      end
      else if (state[cur] == nts_pkg::BUF_FILLING && counter[cur] != '1)
      begin
        wr_en   = 1'b1;       // Full buffer drops the rest
        wr_addr = counter[cur] + 1'b1;
      end
    end
  end

  // Memories and read data path
  always_ff @(posedge i_clk)
  begin
    if (wr_en)
      mem[cur][wr_addr] <= i_word;
    rd_word        <= mem[rd_sel][r_addr];
    o_fifo_rd_data <= rd_word;
  end

  //----------------------------------------
  // Buffer state machines
  //----------------------------------------

  always_ff @(posedge i_clk or posedge i_areset)
  begin
    if (i_areset)
    begin
      cur           <= 1'b0;
      state[0]      <= nts_pkg::BUF_EMPTY;
      state[1]      <= nts_pkg::BUF_EMPTY;
      counter[0]    <= '0;
      counter[1]    <= '0;
      data_valid[0] <= '0;
      data_valid[1] <= '0;
      r_addr        <= '0;
      rd_issue      <= 1'b0;
      fifo_empty    <= 1'b1;
      fifo_rd_valid <= 1'b0;
    end
    else
    begin
      fifo_rd_valid <= rd_issue;

      // Dispatch side
      if (i_packet_discard)
      begin
        state[rd_sel] <= nts_pkg::BUF_EMPTY;
        fifo_empty    <= 1'b1;
        rd_issue      <= 1'b0;
      end
      else
      begin
        case (state[rd_sel])
          nts_pkg::BUF_READY:
          begin
            r_addr     <= '0;
            fifo_empty <= 1'b0;
            if (i_fifo_rd_start)
              state[rd_sel] <= nts_pkg::BUF_START;
          end
          nts_pkg::BUF_START: state[rd_sel] <= nts_pkg::BUF_STREAM;
          nts_pkg::BUF_STREAM:
          begin
            rd_issue <= 1'b1;
            r_addr   <= r_addr + 1'b1;
            if (r_addr == counter[rd_sel])
              state[rd_sel] <= nts_pkg::BUF_DONE;
          end
          nts_pkg::BUF_DONE:
          begin
            rd_issue <= 1'b0;
            if (!rd_issue)
              fifo_empty <= 1'b1; // Last word has left
          end
          default: ;
        endcase
      end

      // Capture side
      if (wr_en)
      begin
        counter[cur]    <= wr_addr;
        data_valid[cur] <= i_rx_data_valid;
      end

      case (state[cur])
        nts_pkg::BUF_EMPTY:
        begin
          if (i_sof && !i_rx_bad_frame)
            state[cur] <= nts_pkg::BUF_FILLING;
        end
        nts_pkg::BUF_FILLING:
        begin
          if (i_rx_bad_frame)
          begin
            state[cur]   <= nts_pkg::BUF_EMPTY;  // Abort, frame dropped
            counter[cur] <= '0;
          end
          else if (i_rx_good_frame)
          begin
            state[cur] <= nts_pkg::BUF_RECEIVED;
          end
        end
        nts_pkg::BUF_RECEIVED:
        begin
          // Swap once the reader has let go
          if (state[rd_sel] == nts_pkg::BUF_EMPTY)
          begin
            state[cur] <= nts_pkg::BUF_READY;
            cur        <= ~cur;
          end
        end
        default: ;
      endcase
    end
  end

  assign o_packet_available    = (state[rd_sel] == nts_pkg::BUF_READY);
  assign o_dispatch_counter    = counter[rd_sel];
  assign o_dispatch_data_valid = data_valid[rd_sel];
  assign o_dispatch_started    = o_packet_available && i_fifo_rd_start && !i_packet_discard;
  assign o_fifo_empty          = fifo_empty;
  assign o_fifo_rd_valid       = fifo_rd_valid;
  assign o_buf_state           = state;

endmodule

/* hdl/mac_rx_frontend.sv */
//----------------------------------------
// MAC receive front end
// Only contiguous low-byte masks are shifted
// Other non-zero masks count as 8 bytes
//----------------------------------------

`timescale 1ns/10ps

module mac_rx_frontend (
  input  logic               i_clk,
  input  logic               i_areset,
  input  nts_pkg::dv_t       i_rx_data_valid,
  input  nts_pkg::word_t     i_rx_data,
  output nts_pkg::word_t     o_word,
  output logic               o_word_valid,
  output logic [3:0]         o_bytes,
  output logic               o_sof
);

  nts_pkg::dv_t prev_dv;
  logic [3:0]   bytes;
  logic [6:0]   shift;   // Bits to move the last word up

  // Last word fix-up, valid bytes end up at the top
  always_comb
  begin
    case (i_rx_data_valid)
      8'h00:   bytes = 4'd0;
      8'h01:   bytes = 4'd1;
      8'h03:   bytes = 4'd2;
      8'h07:   bytes = 4'd3;
      8'h0f:   bytes = 4'd4;
      8'h1f:   bytes = 4'd5;
      8'h3f:   bytes = 4'd6;
      8'h7f:   bytes = 4'd7;
      default: bytes = 4'd8;  // Full word or odd mask
    endcase
    shift  = 7'(4'd8 - bytes) * 7'd8;
    o_word = i_rx_data << shift; // Zero mask gives all zero
  end

  assign o_word_valid = |i_rx_data_valid;
  assign o_bytes      = bytes;

  //----------------------------------------
  // Start of frame
  //----------------------------------------

  // Reset value must be non-zero, else a false SOF
  always_ff @(posedge i_clk or posedge i_areset)
  begin
    if (i_areset)
    begin
      prev_dv <= '1;
    end
    else
    begin
      prev_dv <= i_rx_data_valid;
    end
  end

  // Idle word followed by a full word
  assign o_sof = (prev_dv == '0) && (i_rx_data_valid == '1);

endmodule

/* hdl/nts_defines.svh */
//----------------------------------------
// Project-wide sizes and constants
// Buffer depth is 2**NTS_ADDR_WIDTH words
// Identity values are ASCII, first char in MSB
//----------------------------------------

`ifndef NTS_DEFINES_SVH
`define NTS_DEFINES_SVH

// Frame buffer
`define NTS_ADDR_WIDTH 8

// MAC receive word
`define NTS_WORD_BITS 64
`define NTS_BYTES 8

// Register port
`define NTS_API_ADDR_BITS 12
`define NTS_API_DATA_BITS 32

`define NTS_CORE_NAME 64'h4e54_532d_4449_5350
`define NTS_CORE_VERSION 32'h302e_3031

`endif

/* hdl/nts_dispatcher.sv */
//----------------------------------------
// Dispatcher top level
// Reader must take every valid word
// Register port is read only
//----------------------------------------

`timescale 1ns/10ps

`include "nts_defines.svh"

module nts_dispatcher (
  input  logic                          i_clk,
  input  logic                          i_areset,
  // MAC receive
  input  nts_pkg::dv_t                  i_rx_data_valid,
  input  nts_pkg::word_t                i_rx_data,
  input  logic                          i_rx_good_frame,
  input  logic                          i_rx_bad_frame,
  // Dispatch
  output logic                          o_packet_available,
  input  logic                          i_packet_discard,
  output nts_pkg::buf_addr_t            o_dispatch_counter,
  output nts_pkg::dv_t                  o_dispatch_data_valid,
  output logic                          o_fifo_empty,
  input  logic                          i_fifo_rd_start,
  output logic                          o_fifo_rd_valid,
  output nts_pkg::word_t                o_fifo_rd_data,
  // Registers
  input  logic                          i_api_cs,
  input  logic [`NTS_API_ADDR_BITS-1:0] i_api_address,
  output nts_pkg::reg_t                 o_api_read_data
);

  nts_pkg::word_t      word;
  logic                word_valid;
  logic [3:0]          bytes;
  logic                sof;
  logic                dispatch_started;
  nts_pkg::buf_state_e buf_state [2];
  nts_pkg::count_t     frames;
  nts_pkg::count_t     good;
  nts_pkg::count_t     bad;
  nts_pkg::count_t     dispatched;
  nts_pkg::count_t     bytes_rx;

  mac_rx_frontend frontend_i (
    .i_clk           (i_clk),
    .i_areset        (i_areset),
    .i_rx_data_valid (i_rx_data_valid),
    .i_rx_data       (i_rx_data),
    .o_word          (word),
    .o_word_valid    (word_valid),
    .o_bytes         (bytes),
    .o_sof           (sof)
  );

  frame_buffer buffer_i (
    .i_clk                 (i_clk),
    .i_areset              (i_areset),
    .i_word                (word),
    .i_word_valid          (word_valid),
    .i_sof                 (sof),
    .i_rx_data_valid       (i_rx_data_valid),
    .i_rx_good_frame       (i_rx_good_frame),
    .i_rx_bad_frame        (i_rx_bad_frame),
    .i_fifo_rd_start       (i_fifo_rd_start),
    .i_packet_discard      (i_packet_discard),
    .o_packet_available    (o_packet_available),
    .o_dispatch_counter    (o_dispatch_counter),
    .o_dispatch_data_valid (o_dispatch_data_valid),
    .o_fifo_empty          (o_fifo_empty),
    .o_fifo_rd_valid       (o_fifo_rd_valid),
    .o_fifo_rd_data        (o_fifo_rd_data),
    .o_dispatch_started    (dispatch_started),
    .o_buf_state           (buf_state)
  );

  rx_statistics stats_i (
    .i_clk              (i_clk),
    .i_areset           (i_areset),
    .i_sof              (sof),
    .i_rx_good_frame    (i_rx_good_frame),
    .i_rx_bad_frame     (i_rx_bad_frame),
    .i_dispatch_started (dispatch_started),
    .i_bytes            (bytes),
    .o_frames           (frames),
    .o_good             (good),
    .o_bad              (bad),
    .o_dispatched       (dispatched),
    .o_bytes_rx         (bytes_rx)
  );

  api_regs regs_i (
    .i_clk           (i_clk),
    .i_areset        (i_areset),
    .i_api_cs        (i_api_cs),
    .i_api_address   (i_api_address),
    .i_frames        (frames),
    .i_good          (good),
    .i_bad           (bad),
    .i_dispatched    (dispatched),
    .i_bytes_rx      (bytes_rx),
    .i_buf_state     (buf_state),
    .o_api_read_data (o_api_read_data)
  );

endmodule

/* hdl/nts_pkg.sv */
//----------------------------------------
// Shared types for the dispatcher
// Register addresses are word addresses
//----------------------------------------

`include "nts_defines.svh"

package nts_pkg;

  typedef logic [`NTS_WORD_BITS-1:0] word_t;
  typedef logic [`NTS_BYTES-1:0] dv_t;          // Bit 0 is the lowest byte
  typedef logic [`NTS_ADDR_WIDTH-1:0] buf_addr_t;
  typedef logic [63:0] count_t;
  typedef logic [`NTS_API_DATA_BITS-1:0] reg_t;

  // Capture states first, dispatch states after
  typedef enum logic [2:0] {
    BUF_EMPTY,
    BUF_FILLING,
    BUF_RECEIVED,
    BUF_READY,
    BUF_START,
    BUF_STREAM,
    BUF_DONE
  } buf_state_e;

  typedef enum logic [`NTS_API_ADDR_BITS-1:0] {
    REG_NAME0      = 12'h000,
    REG_NAME1      = 12'h001,
    REG_VERSION    = 12'h002,
    REG_STATUS     = 12'h009,
    REG_BYTES_MSB  = 12'h00a,
    REG_BYTES_LSB  = 12'h00b,
    REG_FRAMES_MSB = 12'h020,
    REG_FRAMES_LSB = 12'h021,
    REG_GOOD_MSB   = 12'h022,
    REG_GOOD_LSB   = 12'h023,
    REG_BAD_MSB    = 12'h024,
    REG_BAD_LSB    = 12'h025,
    REG_DISP_MSB   = 12'h026,
    REG_DISP_LSB   = 12'h027
  } api_addr_e;

endpackage

/* hdl/rx_statistics.sv */
//----------------------------------------
// Receive statistics
// All counters are 64 bit and wrap
//----------------------------------------

`timescale 1ns/10ps

module rx_statistics (
  input  logic            i_clk,
  input  logic            i_areset,
  input  logic            i_sof,
  input  logic            i_rx_good_frame,
  input  logic            i_rx_bad_frame,
  input  logic            i_dispatch_started,
  input  logic [3:0]      i_bytes,
  output nts_pkg::count_t o_frames,
  output nts_pkg::count_t o_good,
  output nts_pkg::count_t o_bad,
  output nts_pkg::count_t o_dispatched,
  output nts_pkg::count_t o_bytes_rx
);

  always_ff @(posedge i_clk or posedge i_areset)
  begin
    if (i_areset)
    begin
      o_frames     <= '0;
      o_good       <= '0;
      o_bad        <= '0;
      o_dispatched <= '0;
      o_bytes_rx   <= '0;
    end
    else
    begin
      if (i_sof)
        o_frames <= o_frames + 1'b1;
      if (i_rx_good_frame)
        o_good <= o_good + 1'b1;
      if (i_rx_bad_frame)
        o_bad <= o_bad + 1'b1;
      if (i_dispatch_started)
        o_dispatched <= o_dispatched + 1'b1;

      // Every valid byte, good or bad frame
      if (i_bytes != 4'd0)
        o_bytes_rx <= o_bytes_rx + 64'(i_bytes);
    end
  end

endmodule

/* run.sh */
#!/bin/sh
# Build and run the dispatcher testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f tb.f --top-module tb_nts_dispatcher -o sim_tb

out=$(./obj_dir/sim_tb)
echo "$out"

if echo "$out" | grep -qx "Everything OK"; then
  exit 0
else
  exit 1
fi

/* tb.f */
+incdir+hdl
hdl/nts_pkg.sv
hdl/mac_rx_frontend.sv
hdl/frame_buffer.sv
hdl/rx_statistics.sv
hdl/api_regs.sv
hdl/nts_dispatcher.sv
tests/dispatch_checker.sv
tests/tb_nts_dispatcher.sv

/* tests/dispatch_cases.txt */
# words(dec) last_mask(hex, bit 0 lowest byte) bad(0/1) discard_before_read(0/1)
# Last masks are contiguous low-byte forms or ff
4 ff 0 0
2 01 0 0
3 03 0 0
5 07 0 0
2 0f 0 0
6 1f 0 0
3 3f 0 0
7 7f 0 0
4 0f 1 0
3 ff 0 0
5 3f 0 1
2 07 0 0
8 01 1 0
6 ff 1 0
4 1f 0 0
12 7f 0 1
9 03 0 0
20 ff 0 0
16 0f 0 0
2 ff 1 0
5 01 0 0

/* tests/dispatch_checker.sv */
//----------------------------------------
// Scoreboard for the dispatcher
// Expected data is pushed by the testbench
// Samples DUT outputs on the rising edge
//----------------------------------------

`timescale 1ns/10ps

module dispatch_checker (
  input  logic               i_clk,
  input  logic               i_areset,
  input  logic               i_packet_available,
  input  nts_pkg::buf_addr_t i_dispatch_counter,
  input  nts_pkg::dv_t       i_dispatch_data_valid,
  input  logic               i_fifo_empty,
  input  logic               i_fifo_rd_valid,
  input  nts_pkg::word_t     i_fifo_rd_data,
  input  logic               i_api_cs,
  input  nts_pkg::reg_t      i_api_read_data
);

  int                 errors = 0;
  nts_pkg::word_t     word_q [$];   // Aligned words still to come
  nts_pkg::buf_addr_t cnt_q [$];    // Last word index per good frame
  nts_pkg::dv_t       mask_q [$];
  nts_pkg::reg_t      reg_q [$];    // Register read data in order
  logic               avail_d = 1'b0;
  nts_pkg::word_t     exp_word;
  nts_pkg::reg_t      exp_reg;

  // Low n bytes of a low-byte run land in the top n bytes
  function automatic nts_pkg::word_t align_last(nts_pkg::word_t w, nts_pkg::dv_t m);
    int             n;
    nts_pkg::word_t r;
    n = $countones(m);
    if (m != nts_pkg::dv_t'((9'd1 << n) - 1))
      n = 8;   // Not a low-byte run
    r = '0;
    for (int k = 0; k < n; k++)
      r[8 * (8 - n + k) +: 8] = w[8 * k +: 8];
    return r;
  endfunction

  task automatic mismatch(string name, logic [63:0] got, logic [63:0] exp);
    errors++;
    $display("** Error at %0t ns: %s got %h expected %h", $time, name, got, exp);
  endtask

  task automatic failure(string msg);
    errors++;
    $display("Failure at %0t ns: %s", $time, msg);
  endtask

  //----------------------------------------
  // Expectations from the testbench
  //----------------------------------------

  task automatic expect_frame(nts_pkg::buf_addr_t last_idx, nts_pkg::dv_t mask);
    cnt_q.push_back(last_idx);
    mask_q.push_back(mask);
  endtask

  task automatic expect_word(nts_pkg::word_t w, logic last, nts_pkg::dv_t mask);
    if (last)
      word_q.push_back(align_last(w, mask));
    else
      word_q.push_back(w);
  endtask

  task automatic expect_reg(nts_pkg::reg_t v);
    reg_q.push_back(v);
  endtask

  task automatic check_reset();
    if (i_fifo_rd_valid !== 1'b0)
      mismatch("o_fifo_rd_valid", 64'(i_fifo_rd_valid), 64'd0);
    if (i_packet_available !== 1'b0)
      mismatch("o_packet_available", 64'(i_packet_available), 64'd0);
    if (i_fifo_empty !== 1'b1)
      mismatch("o_fifo_empty", 64'(i_fifo_empty), 64'd1);
  endtask

  // After a discard without reading
  task automatic check_idle();
    if (i_fifo_empty !== 1'b1)
      mismatch("o_fifo_empty", 64'(i_fifo_empty), 64'd1);
    if (i_packet_available !== 1'b0)
      mismatch("o_packet_available", 64'(i_packet_available), 64'd0);
  endtask

  task automatic frame_done();
    if (word_q.size() != 0)
      failure($sformatf("%0d frame words were never dispatched", word_q.size()));
    word_q.delete();
  endtask

  task automatic final_check();
    frame_done();
    if (cnt_q.size() != 0)
      failure("a good frame never became available");
    if (reg_q.size() != 0)
      failure("a register read was never seen");
  endtask

  //----------------------------------------
  // Port monitor
  //----------------------------------------

  always @(posedge i_clk)
  begin
    if (!i_areset)
    begin
      if (i_fifo_rd_valid)
      begin
        if (word_q.size() == 0)
          failure("word on the read stream with none expected");
        else
        begin
          exp_word = word_q.pop_front();
          if (i_fifo_rd_data !== exp_word)
            mismatch("o_fifo_rd_data", i_fifo_rd_data, exp_word);
        end
      end

      // Frame info checked once as it shows up
      if (i_packet_available && !avail_d)
      begin
        if (cnt_q.size() == 0)
          failure("a frame became available with none expected");
        else
        begin
          if (i_dispatch_counter !== cnt_q[0])
            mismatch("o_dispatch_counter", 64'(i_dispatch_counter), 64'(cnt_q[0]));
          if (i_dispatch_data_valid !== mask_q[0])
            mismatch("o_dispatch_data_valid", 64'(i_dispatch_data_valid), 64'(mask_q[0]));
          void'(cnt_q.pop_front());
          void'(mask_q.pop_front());
        end
      end

      if (i_api_cs)
      begin
        if (reg_q.size() == 0)
          failure("register read with no expected value");
        else
        begin
          exp_reg = reg_q.pop_front();
          if (i_api_read_data !== exp_reg)
            mismatch("o_api_read_data", 64'(i_api_read_data), 64'(exp_reg));
        end
      end
    end
    avail_d <= i_packet_available;
  end

endmodule

/* tests/tb_nts_dispatcher.sv */
//----------------------------------------
// Dispatcher testbench
// Case file path is relative to the project root
// Frames need at least two words for SOF
//----------------------------------------

`timescale 1ns/10ps

`include "nts_defines.svh"

module tb_nts_dispatcher;

  localparam int          MAX_CASES = 64;
  localparam logic [63:0] CORE_NAME = `NTS_CORE_NAME;

  logic                          clk = 1'b0;
  logic                          areset;
  nts_pkg::dv_t                  rx_data_valid;
  nts_pkg::word_t                rx_data;
  logic                          rx_good_frame;
  logic                          rx_bad_frame;
  logic                          packet_discard;
  logic                          fifo_rd_start;
  logic                          api_cs;
  logic [`NTS_API_ADDR_BITS-1:0] api_address;

  logic                          o_packet_available;
  nts_pkg::buf_addr_t            o_dispatch_counter;
  nts_pkg::dv_t                  o_dispatch_data_valid;
  logic                          o_fifo_empty;
  logic                          o_fifo_rd_valid;
  nts_pkg::word_t                o_fifo_rd_data;
  nts_pkg::reg_t                 o_api_read_data;

  int           case_words [MAX_CASES];
  nts_pkg::dv_t case_mask [MAX_CASES];
  logic         case_bad [MAX_CASES];
  logic         case_discard [MAX_CASES];
  int           num_cases = 0;
  int           limit_cycles = 0;
  logic [31:0]  lfsr = 32'd82034;

  // Counter values tallied from the cases
  logic [63:0]  n_frames = '0;
  logic [63:0]  n_good = '0;
  logic [63:0]  n_bad = '0;
  logic [63:0]  n_disp = '0;
  logic [63:0]  n_bytes = '0;

  always #4 clk = ~clk;

  nts_dispatcher dut_i (
    .i_clk                 (clk),
    .i_areset              (areset),
    .i_rx_data_valid       (rx_data_valid),
    .i_rx_data             (rx_data),
    .i_rx_good_frame       (rx_good_frame),
    .i_rx_bad_frame        (rx_bad_frame),
    .o_packet_available    (o_packet_available),
    .i_packet_discard      (packet_discard),
    .o_dispatch_counter    (o_dispatch_counter),
    .o_dispatch_data_valid (o_dispatch_data_valid),
    .o_fifo_empty          (o_fifo_empty),
    .i_fifo_rd_start       (fifo_rd_start),
    .o_fifo_rd_valid       (o_fifo_rd_valid),
    .o_fifo_rd_data        (o_fifo_rd_data),
    .i_api_cs              (api_cs),
    .i_api_address         (api_address),
    .o_api_read_data       (o_api_read_data)
  );

  dispatch_checker chk_i (
    .i_clk                 (clk),
    .i_areset              (areset),
    .i_packet_available    (o_packet_available),
    .i_dispatch_counter    (o_dispatch_counter),
    .i_dispatch_data_valid (o_dispatch_data_valid),
    .i_fifo_empty          (o_fifo_empty),
    .i_fifo_rd_valid       (o_fifo_rd_valid),
    .i_fifo_rd_data        (o_fifo_rd_data),
    .i_api_cs              (api_cs),
    .i_api_read_data       (o_api_read_data)
  );

  //----------------------------------------
  // Payload generator
  //----------------------------------------

  function automatic logic next_bit();
    logic b;
    b    = lfsr[0];
    lfsr = lfsr >> 1;
    if (b)
      lfsr = lfsr ^ 32'hb4bc_d35c;  // Galois taps
    return b;
  endfunction

  function automatic nts_pkg::word_t random_word();
    nts_pkg::word_t w;
    w = '0;
    for (int i = 0; i < 64; i++)
      w = {w[62:0], next_bit()};
    return w;
  endfunction

  task automatic read_cases();
    int          fd;
    int          words;
    int          bad;
    int          disc;
    logic [7:0]  mask;
    string       line;
    fd = $fopen("tests/dispatch_cases.txt", "r");
    if (fd == 0)
    begin
      chk_i.failure("cannot open tests/dispatch_cases.txt");
      return;
    end
    while (!$feof(fd) && num_cases < MAX_CASES)
    begin
      line = "";
      void'($fgets(line, fd));
      if (line.len() > 0 && line[0] != 8'h23)   // Skip comment lines
      begin
        if ($sscanf(line, "%d %h %d %d", words, mask, bad, disc) == 4)
        begin
          case_words[num_cases]   = words;
          case_mask[num_cases]    = mask;
          case_bad[num_cases]     = (bad != 0);
          case_discard[num_cases] = (disc != 0);
          num_cases++;
        end
      end
    end
    $fclose(fd);
  endtask

  //----------------------------------------
  // MAC side and reader side
  //----------------------------------------

  task automatic send_frame(int idx);
    nts_pkg::word_t w;
    nts_pkg::dv_t   m;
    int             n;
    n = case_words[idx];
    @(negedge clk);
    rx_data_valid = '0;        // Idle word ahead of SOF
    rx_data       = '0;
    for (int i = 0; i < n; i++)
    begin
      @(negedge clk);
      w             = random_word();
      m             = (i == n - 1) ? case_mask[idx] : 8'hff;
      rx_data       = w;
      rx_data_valid = m;
      if (!case_bad[idx] && !case_discard[idx])
        chk_i.expect_word(w, i == n - 1, m);
    end
    @(negedge clk);
    rx_data_valid = '0;
    rx_data       = '0;
    rx_good_frame = !case_bad[idx];
    rx_bad_frame  = case_bad[idx];
    @(negedge clk);
    rx_good_frame = 1'b0;
    rx_bad_frame  = 1'b0;
    n_frames = n_frames + 64'd1;
    n_bytes  = n_bytes + 64'(8 * (n - 1) + $countones(case_mask[idx]));
  endtask

  task automatic pulse_discard();
    packet_discard = 1'b1;
    @(negedge clk);
    packet_discard = 1'b0;
  endtask

  task automatic take_frame(int idx);
    int t;
    t = 0;
    chk_i.expect_frame(nts_pkg::buf_addr_t'(case_words[idx] - 1), case_mask[idx]);
    while (!o_packet_available && t < 200)
    begin
      @(negedge clk);
      t++;
    end
    if (!o_packet_available)
    begin
      chk_i.failure("good frame never became available");
      return;
    end
    if (case_discard[idx])
    begin
      @(negedge clk);          // Buffer now reports not empty
      pulse_discard();
      chk_i.check_idle();
      return;
    end
    fifo_rd_start = 1'b1;
    @(negedge clk);
    fifo_rd_start = 1'b0;
    n_disp = n_disp + 64'd1;
    t = 0;
    while ((!o_fifo_empty || o_fifo_rd_valid) && t < 400)
    begin
      @(negedge clk);
      t++;
    end
    if (!o_fifo_empty)
      chk_i.failure("read stream did not finish");
    pulse_discard();
    chk_i.frame_done();
  endtask

  //----------------------------------------
  // Register reads
  //----------------------------------------

  task automatic read_reg(nts_pkg::api_addr_e addr, nts_pkg::reg_t exp);
    chk_i.expect_reg(exp);
    api_cs      = 1'b1;
    api_address = addr;
    @(negedge clk);
    api_cs      = 1'b0;
  endtask

  // MSB read latches the LSB
  task automatic read_counter(nts_pkg::api_addr_e msb, nts_pkg::api_addr_e lsb,
                              logic [63:0] v);
    read_reg(msb, v[63:32]);
    read_reg(lsb, v[31:0]);
  endtask

  //----------------------------------------
  // Main sequence
  //----------------------------------------

  initial
  begin
    int total;
    areset         = 1'b1;
    rx_data_valid  = '0;
    rx_data        = '0;
    rx_good_frame  = 1'b0;
    rx_bad_frame   = 1'b0;
    packet_discard = 1'b0;
    fifo_rd_start  = 1'b0;
    api_cs         = 1'b0;
    api_address    = '0;

    read_cases();
    total = 0;
    for (int i = 0; i < num_cases; i++)
      total += case_words[i];
    limit_cycles = total * 40 + 500;

    repeat (4) @(posedge clk);
    @(negedge clk);
    areset = 1'b0;
    @(negedge clk);
    chk_i.check_reset();

    for (int i = 0; i < num_cases; i++)
    begin
      send_frame(i);
      if (case_bad[i])
      begin
        n_bad = n_bad + 64'd1;
        repeat (12) @(negedge clk);   // Checker flags any availability
      end
      else
      begin
        n_good = n_good + 64'd1;
        take_frame(i);
      end
    end

    repeat (4) @(negedge clk);
    read_counter(nts_pkg::REG_FRAMES_MSB, nts_pkg::REG_FRAMES_LSB, n_frames);
    read_counter(nts_pkg::REG_GOOD_MSB, nts_pkg::REG_GOOD_LSB, n_good);
    read_counter(nts_pkg::REG_BAD_MSB, nts_pkg::REG_BAD_LSB, n_bad);
    read_counter(nts_pkg::REG_DISP_MSB, nts_pkg::REG_DISP_LSB, n_disp);
    read_counter(nts_pkg::REG_BYTES_MSB, nts_pkg::REG_BYTES_LSB, n_bytes);
    read_reg(nts_pkg::REG_NAME0, CORE_NAME[63:32]);
    read_reg(nts_pkg::REG_NAME1, CORE_NAME[31:0]);
    read_reg(nts_pkg::REG_VERSION, `NTS_CORE_VERSION);
    read_reg(nts_pkg::REG_STATUS, 32'h0000_0003);  // Both buffers empty and no frame ready
    repeat (2) @(negedge clk);

    chk_i.final_check();
    $display("Cases run: %0d, errors: %0d", num_cases, chk_i.errors);
    if (chk_i.errors == 0)
      $display("Everything OK");
    else
      $display("Something failed");
    $finish;
  end

  // Watchdog armed once the cases are known
  initial
  begin
    wait (limit_cycles > 0);
    repeat (limit_cycles) @(posedge clk);
    $display("Timeout after %0d cycles, the run did not finish", limit_cycles);
    $display("Something failed");
    $finish;
  end

endmodule
